// ==== Makefile ====
# Verilator build and run for the emio subsystem testbench

VERILATOR ?= verilator
TOP       ?= emio_tb
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -j 0

SRCS    := $(shell grep -v '^+' $(FILELIST))
HEADERS := logic/emio_bus_macros.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== compile.f ====
+incdir+logic
logic/emio_bus_pkg.sv
logic/bus_arbiter.sv
logic/register_bank.sv
logic/heartbeat_writer.sv
logic/emio_bridge.sv
logic/emio_subsystem_top.sv
verification/tb_clock_gen.sv
verification/emio_bridge_chk.sv
verification/emio_tb.sv

// ==== logic/bus_arbiter.sv ====
// two-requester round-robin arbiter for one register bus
// a grant is held while its request stays up, the payload and wen of the
// granted master are forwarded
`timescale 1ns/1ps

module bus_arbiter #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     sysclk,
    input  logic     reset,
    input  logic     req_a,
    input  logic     req_b,
    input  payload_t payload_a,
    input  payload_t payload_b,
    input  logic     wen_a,
    input  logic     wen_b,
    output logic     grant_a,
    output logic     grant_b,
    output payload_t payload,
    output logic     wen
);

    logic last_b;         // b won the last arbitration
    logic grant_a_nxt;
    logic grant_b_nxt;

    always_comb begin
        grant_a_nxt = 1'b0;
        grant_b_nxt = 1'b0;
        if (grant_a && req_a) begin
            grant_a_nxt = 1'b1;              // holder keeps the bus
        end else if (grant_b && req_b) begin
            grant_b_nxt = 1'b1;
        end else if (req_a && req_b) begin
            grant_a_nxt = last_b;            // the one not served last
            grant_b_nxt = ~last_b;
        end else begin
            grant_a_nxt = req_a;
            grant_b_nxt = req_b;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            grant_a <= 1'b0;
            grant_b <= 1'b0;
            last_b  <= 1'b0;
        end else begin
            grant_a <= grant_a_nxt;
            grant_b <= grant_b_nxt;
            if (grant_a_nxt)
                last_b <= 1'b0;
            else if (grant_b_nxt)
                last_b <= 1'b1;
        end
    end

    assign payload = grant_b ? payload_b : payload_a;
    assign wen     = (grant_a & wen_a) | (grant_b & wen_b);    // ungranted wen is dropped

endmodule

// ==== logic/emio_bridge.sv ====
// emio bridge, turns the processor's 64-bit emio port into register bus cycles
// quadlet and block read/write, abort on a falling request and the
// timestamp delta for real-time block reads of main address 0
`timescale 1ns/1ps
`include "emio_bus_macros.svh"

module emio_bridge (
    input  logic                    sysclk,
    input  logic                    reset,
    input  logic [63:0]             emio_ps_out,     // driven by the processor
    input  logic [63:0]             emio_ps_tri,     // 1 = bit is an input to the processor
    input  emio_bus_pkg::reg_data_t reg_rdata,
    input  logic                    reg_rvalid,
    input  logic                    grant_read_bus,
    input  logic                    grant_write_bus,
    input  emio_bus_pkg::reg_data_t timestamp,
    output logic [63:0]             emio_ps_in,
    output emio_bus_pkg::reg_addr_t reg_raddr,
    output logic                    req_read_bus,
    output emio_bus_pkg::wr_req_t   wr_payload,
    output logic                    reg_wen,
    output logic                    req_write_bus
);

    // raw processor fields, data is only used once the address has settled
    emio_bus_pkg::reg_addr_t ps_reg_addr;
    emio_bus_pkg::reg_data_t ps_reg_wdata;
    logic                    ps_req;
    logic                    ps_wen;            // echoed only
    logic                    ps_blk_start;
    logic                    ps_blk_end;
    logic                    ps_write;

    // sysclk side copies
    logic [1:0]              ps_req_sync;       // two-flop synchronizer
    logic                    ps_req_prev;       // edge detect behind it
    emio_bus_pkg::reg_addr_t ps_addr_latched;
    logic                    ps_blk_start_latched;
    logic                    ps_blk_end_latched;
    logic                    req_rise;
    logic                    req_fall;

    emio_bus_pkg::bridge_state_t state;
    logic                    reg_op_done;
    logic                    first_quad;        // current block quadlet not yet written
    logic                    blk_rt_rd;         // real-time block read in progress
    logic                    rt_start;
    logic                    timestamp_rd;
    logic                    addr_main;
    logic                    addr_match;
    logic                    raddr_diff;
    logic                    waddr_diff;
    emio_bus_pkg::reg_data_t rdata_latched;
    emio_bus_pkg::reg_data_t timestamp_prev;    // timestamp at the last real-time start
    emio_bus_pkg::reg_data_t timestamp_delta;

    assign ps_reg_wdata = emio_ps_out[`EMIO_DATA_MSB:`EMIO_DATA_LSB];
    assign ps_reg_addr  = emio_ps_out[`EMIO_ADDR_MSB:`EMIO_ADDR_LSB];
    assign ps_req       = emio_ps_out[`EMIO_REQ_BIT];
    assign ps_wen       = emio_ps_out[`EMIO_WEN_BIT];
    assign ps_blk_start = emio_ps_out[`EMIO_BLK_START_BIT];
    assign ps_blk_end   = emio_ps_out[`EMIO_BLK_END_BIT];

    // every data bit driven by the processor means a write
    assign ps_write = (emio_ps_tri[`EMIO_DATA_MSB:`EMIO_DATA_LSB] == 32'd0);

    assign req_rise = ps_req_sync[1] & ~ps_req_prev;
    assign req_fall = ~ps_req_sync[1] & ps_req_prev;

    assign addr_main    = (ps_addr_latched[15:12] == `ADDR_MAIN);
    assign rt_start     = ~ps_write & ps_blk_start_latched & addr_main;
    assign timestamp_rd = blk_rt_rd && (reg_raddr == {`ADDR_MAIN, 12'h000});
    assign raddr_diff   = (reg_raddr != ps_addr_latched);
    assign waddr_diff   = (wr_payload.addr != ps_addr_latched);

    // op_done only counts for the address the processor is looking at
    assign addr_match = ps_write ? (ps_reg_addr == wr_payload.addr) : (ps_reg_addr == reg_raddr);

    assign emio_ps_in[`EMIO_VERSION_MSB:`EMIO_VERSION_LSB] = `EMIO_VERSION;
    assign emio_ps_in[59:55]                 = 5'd0;    // spare
    assign emio_ps_in[`EMIO_GRANT_BIT]       = ps_write ? grant_write_bus : grant_read_bus;
    assign emio_ps_in[`EMIO_WRITE_BIT]       = ps_write;
    assign emio_ps_in[`EMIO_BLK_END_BIT]     = ps_blk_end;
    assign emio_ps_in[`EMIO_BLK_START_BIT]   = ps_blk_start;
    assign emio_ps_in[`EMIO_WEN_BIT]         = ps_wen;
    assign emio_ps_in[`EMIO_OP_DONE_BIT]     = reg_op_done & addr_match;
    assign emio_ps_in[`EMIO_REQ_BIT]         = ps_req;
    assign emio_ps_in[`EMIO_ADDR_MSB:`EMIO_ADDR_LSB] = ps_reg_addr;
    assign emio_ps_in[`EMIO_DATA_MSB:`EMIO_DATA_LSB] = ps_write ? ps_reg_wdata : rdata_latched;

    always_ff @(posedge sysclk) begin
        if (reset) begin
            ps_req_sync    <= 2'b00;
            ps_req_prev    <= 1'b0;
            state          <= emio_bus_pkg::ST_IDLE;
            req_read_bus   <= 1'b0;
            req_write_bus  <= 1'b0;
            reg_wen        <= 1'b0;
            reg_op_done    <= 1'b0;
            first_quad     <= 1'b0;
            blk_rt_rd      <= 1'b0;
            timestamp_prev <= '0;
        end else begin
            ps_req_sync          <= {ps_req_sync[0], ps_req};
            ps_req_prev          <= ps_req_sync[1];
            ps_addr_latched      <= ps_reg_addr;
            ps_blk_start_latched <= ps_blk_start;
            ps_blk_end_latched   <= ps_blk_end;

            case (state)
                emio_bus_pkg::ST_IDLE: begin
                    reg_op_done <= 1'b0;
                    reg_wen     <= 1'b0;
                    if (req_rise) begin
                        first_quad <= 1'b1;
                        if (rt_start) begin
                            timestamp_delta <= (timestamp - timestamp_prev) - 32'd1;
                            timestamp_prev  <= timestamp;
                        end
                        if (!ps_write) begin
                            req_read_bus <= 1'b1;
                            reg_raddr    <= ps_addr_latched;
                            blk_rt_rd    <= rt_start;
                            state        <= emio_bus_pkg::ST_READ;
                        end else begin
                            req_write_bus   <= 1'b1;
                            wr_payload.addr <= ps_addr_latched;
                            wr_payload.data <= ps_reg_wdata;
                            state <= ps_blk_start_latched ? emio_bus_pkg::ST_WRITE_BLOCK
                                                          : emio_bus_pkg::ST_WRITE_QUAD;
                        end
                    end else begin
                        req_read_bus  <= 1'b0;    // release both buses
                        req_write_bus <= 1'b0;
                    end
                end

                emio_bus_pkg::ST_READ: begin
                    if (req_read_bus && grant_read_bus) begin
                        if (raddr_diff) begin
                            reg_raddr   <= ps_addr_latched;    // next block quadlet
                            reg_op_done <= 1'b0;
                        end else if (reg_rvalid) begin
                            rdata_latched <= timestamp_rd ? timestamp_delta : reg_rdata;
                            reg_op_done   <= 1'b1;
                            req_read_bus  <= ps_blk_start_latched & ~ps_blk_end_latched;
                        end
                    end
                end

                emio_bus_pkg::ST_WRITE_QUAD: begin
                    if (req_write_bus && grant_write_bus) begin
                        reg_wen <= 1'b1;    // payload already latched
                        state   <= emio_bus_pkg::ST_WRITE_FINISH;
                    end
                end

                emio_bus_pkg::ST_WRITE_BLOCK: begin
                    if (req_write_bus && grant_write_bus) begin
                        if (first_quad) begin
                            first_quad <= 1'b0;
                            reg_wen    <= 1'b1;
                        end else if (waddr_diff) begin
                            wr_payload.addr <= ps_addr_latched;    // processor moved on
                            wr_payload.data <= ps_reg_wdata;
                            reg_wen         <= 1'b1;
                            reg_op_done     <= 1'b0;
                        end else begin
                            reg_wen     <= 1'b0;
                            reg_op_done <= ~ps_blk_end_latched;
                            if (ps_blk_end_latched)
                                state <= emio_bus_pkg::ST_WRITE_FINISH;
                        end
                    end else begin
                        reg_wen    <= 1'b0;    // bus lost, redo this quadlet
                        first_quad <= 1'b1;
                    end
                end

                emio_bus_pkg::ST_WRITE_FINISH: begin
                    reg_wen       <= 1'b0;
                    req_write_bus <= 1'b0;
                    reg_op_done   <= 1'b1;
                end

                default: state <= emio_bus_pkg::ST_IDLE;
            endcase

            // falling req ends any transfer and wins over the fsm
            if (req_fall) begin
                state       <= emio_bus_pkg::ST_IDLE;
                reg_op_done <= 1'b0;
                reg_wen     <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/emio_bus_macros.svh ====
// address map, emio bit positions and heartbeat timing for the register bus
`ifndef EMIO_BUS_MACROS_SVH
`define EMIO_BUS_MACROS_SVH

// address space nibbles, addr[15:12]
`define ADDR_MAIN            4'h0
`define ADDR_HUB             4'h1
`define HUB_HEARTBEAT_ADDR   16'h1004

// emio word layout
`define EMIO_VERSION         4'd1
`define EMIO_VERSION_MSB     63
`define EMIO_VERSION_LSB     60
`define EMIO_GRANT_BIT       54
`define EMIO_WRITE_BIT       53
`define EMIO_BLK_END_BIT     52
`define EMIO_BLK_START_BIT   51
`define EMIO_WEN_BIT         50
`define EMIO_OP_DONE_BIT     49
`define EMIO_REQ_BIT         48
`define EMIO_ADDR_MSB        47
`define EMIO_ADDR_LSB        32
`define EMIO_DATA_MSB        31
`define EMIO_DATA_LSB        0

// cycles between heartbeat writes
`define HEARTBEAT_PERIOD     200

`endif

// ==== logic/emio_bus_pkg.sv ====
// register bus types shared by the emio bridge, the arbiters and the register bank
// quadlet addressing, write bus payload and bridge fsm encoding
package emio_bus_pkg;

    typedef logic [15:0] reg_addr_t;    // [15:12] selects the address space
    typedef logic [31:0] reg_data_t;    // one quadlet

    // write bus payload, address in the upper 16 bits
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } wr_req_t;

    // bridge fsm
    typedef enum logic [2:0] {
        ST_IDLE         = 3'd0,    // waiting for a processor request
        ST_READ         = 3'd1,    // quadlet or block read
        ST_WRITE_QUAD   = 3'd2,    // single quadlet, waits for the write grant
        ST_WRITE_BLOCK  = 3'd3,    // one quadlet per address change
        ST_WRITE_FINISH = 3'd4     // write done, held until req falls
    } bridge_state_t;

endpackage

// ==== logic/emio_subsystem_top.sv ====
// emio subsystem top, the bridge and the heartbeat writer share the register
// bank through one read arbiter and one write arbiter
`timescale 1ns/1ps

module emio_subsystem_top (
    input  logic        sysclk,
    input  logic        reset,
    input  logic [63:0] emio_ps_out,
    input  logic [63:0] emio_ps_tri,
    output logic [63:0] emio_ps_in
);

    emio_bus_pkg::reg_addr_t bridge_raddr;
    emio_bus_pkg::reg_addr_t bank_raddr;
    emio_bus_pkg::reg_data_t reg_rdata;
    emio_bus_pkg::reg_data_t timestamp;
    logic                    reg_rvalid;
    logic                    req_read;
    logic                    grant_read;
    emio_bus_pkg::wr_req_t   bridge_wr;
    emio_bus_pkg::wr_req_t   hb_wr;
    emio_bus_pkg::wr_req_t   bank_wr;
    logic                    bridge_wen;
    logic                    hb_wen;
    logic                    bank_wen;
    logic                    req_write;
    logic                    grant_write;
    logic                    hb_req;
    logic                    hb_grant;

    emio_bridge bridge (
        .sysclk(sysclk), .reset(reset),
        .emio_ps_out(emio_ps_out), .emio_ps_tri(emio_ps_tri), .emio_ps_in(emio_ps_in),
        .reg_raddr(bridge_raddr), .reg_rdata(reg_rdata), .reg_rvalid(reg_rvalid),
        .req_read_bus(req_read), .grant_read_bus(grant_read),
        .wr_payload(bridge_wr), .reg_wen(bridge_wen),
        .req_write_bus(req_write), .grant_write_bus(grant_write),
        .timestamp(timestamp)
    );

    heartbeat_writer heartbeat (
        .sysclk(sysclk), .reset(reset),
        .grant(hb_grant), .req(hb_req), .payload(hb_wr), .wen(hb_wen)
    );

    // read bus, only the bridge reads
    bus_arbiter #(.payload_t(emio_bus_pkg::reg_addr_t)) read_arb (
        .sysclk(sysclk), .reset(reset),
        .req_a(req_read), .req_b(1'b0),
        .payload_a(bridge_raddr), .payload_b('0),
        .wen_a(1'b0), .wen_b(1'b0),
        .grant_a(grant_read), .grant_b(),
        .payload(bank_raddr), .wen()
    );

    bus_arbiter #(.payload_t(emio_bus_pkg::wr_req_t)) write_arb (
        .sysclk(sysclk), .reset(reset),
        .req_a(req_write), .req_b(hb_req),
        .payload_a(bridge_wr), .payload_b(hb_wr),
        .wen_a(bridge_wen), .wen_b(hb_wen),
        .grant_a(grant_write), .grant_b(hb_grant),
        .payload(bank_wr), .wen(bank_wen)
    );

    register_bank bank (
        .sysclk(sysclk), .reset(reset),
        .raddr(bank_raddr), .rd_granted(grant_read),
        .waddr_wdata(bank_wr), .wen(bank_wen),
        .rdata(reg_rdata), .rvalid(reg_rvalid), .timestamp(timestamp)
    );

endmodule

// ==== logic/heartbeat_writer.sv ====
// heartbeat master on the write bus
// every PERIOD cycles it writes its beat count to the hub heartbeat register
`timescale 1ns/1ps
`include "emio_bus_macros.svh"

module heartbeat_writer #(
    parameter int PERIOD = `HEARTBEAT_PERIOD
) (
    input  logic                  sysclk,
    input  logic                  reset,
    input  logic                  grant,
    output logic                  req,
    output emio_bus_pkg::wr_req_t payload,
    output logic                  wen
);

    localparam int CNT_W = (PERIOD > 1) ? $clog2(PERIOD) : 1;

    logic [CNT_W-1:0]        period_cnt;
    emio_bus_pkg::reg_data_t beat_cnt;      // value of the next write
    logic                    tick;

    assign tick = (period_cnt == CNT_W'(PERIOD - 1));

    always_ff @(posedge sysclk) begin
        if (reset) begin
            period_cnt <= '0;
            beat_cnt   <= '0;
            req        <= 1'b0;
            wen        <= 1'b0;
        end else begin
            period_cnt <= tick ? '0 : period_cnt + 1'b1;
            if (wen) begin
                wen      <= 1'b0;           // single wen cycle
                req      <= 1'b0;
                beat_cnt <= beat_cnt + 32'd1;
            end else if (req && grant) begin
                wen <= 1'b1;
            end else if (tick) begin
                req <= 1'b1;                // no effect while a write is pending
            end
        end
    end

    assign payload.addr = `HUB_HEARTBEAT_ADDR;
    assign payload.data = beat_cnt;

endmodule

// ==== logic/register_bank.sv ====
// register bank behind the read and write buses
// sixteen main registers, the hub heartbeat register and a free-running timestamp
`timescale 1ns/1ps
`include "emio_bus_macros.svh"

module register_bank (
    input  logic                    sysclk,
    input  logic                    reset,
    input  emio_bus_pkg::reg_addr_t raddr,
    input  logic                    rd_granted,
    input  emio_bus_pkg::wr_req_t   waddr_wdata,
    input  logic                    wen,
    output emio_bus_pkg::reg_data_t rdata,
    output logic                    rvalid,
    output emio_bus_pkg::reg_data_t timestamp
);

    emio_bus_pkg::reg_data_t main_regs [16];
    emio_bus_pkg::reg_data_t heartbeat_reg;
    emio_bus_pkg::reg_data_t rd_word;
    emio_bus_pkg::reg_addr_t raddr_q;       // address behind rdata
    logic                    rd_granted_q;
    logic                    wr_main;
    logic                    wr_heartbeat;

    // main space uses addr[3:0] only, the rest of the space is unmapped
    always_comb begin
        if (raddr[15:4] == {`ADDR_MAIN, 8'h00})
            rd_word = main_regs[raddr[3:0]];
        else if (raddr == `HUB_HEARTBEAT_ADDR)
            rd_word = heartbeat_reg;
        else
            rd_word = 32'hDEADBEEF;
    end

    assign wr_main      = wen && (waddr_wdata.addr[15:4] == {`ADDR_MAIN, 8'h00});
    assign wr_heartbeat = wen && (waddr_wdata.addr == `HUB_HEARTBEAT_ADDR);

    always_ff @(posedge sysclk) begin
        if (wr_main)
            main_regs[waddr_wdata.addr[3:0]] <= waddr_wdata.data;
        rdata   <= rd_word;
        raddr_q <= raddr;
    end

    always_ff @(posedge sysclk) begin
        if (reset) begin
            heartbeat_reg <= '0;
            timestamp     <= '0;
            rd_granted_q  <= 1'b0;
        end else begin
            timestamp    <= timestamp + 32'd1;    // free running
            rd_granted_q <= rd_granted;
            if (wr_heartbeat)
                heartbeat_reg <= waddr_wdata.data;
        end
    end

    // valid once the granted address has been stable for a cycle
    assign rvalid = rd_granted_q && (raddr == raddr_q);

endmodule

// ==== verification/emio_bridge_chk.sv ====
// bus handshake assertions for the emio bridge, bound into emio_bridge
`timescale 1ns/1ps

module emio_bridge_chk (
    input logic                        sysclk,
    input logic                        reset,
    input emio_bus_pkg::bridge_state_t state,
    input logic                        reg_wen,
    input logic                        grant_write_bus,
    input logic                        req_read_bus,
    input logic                        req_write_bus,
    input logic                        reg_op_done
);

    // a write strobe only goes out on a granted bus
    wen_needs_grant: assert property (
        @(posedge sysclk) disable iff (reset)
        reg_wen |-> grant_write_bus
    ) else $error("reg_wen high without a write grant");

    // block write keeps the bus until it finishes
    block_holds_req: assert property (
        @(posedge sysclk) disable iff (reset)
        (state == emio_bus_pkg::ST_WRITE_BLOCK && grant_write_bus) |=> req_write_bus
    ) else $error("write request dropped in the middle of a block write");

    idle_no_done: assert property (
        @(posedge sysclk) disable iff (reset)
        (state == emio_bus_pkg::ST_IDLE) |-> !reg_op_done
    ) else $error("op_done high while the bridge is idle");

    // everything quiet right out of reset
    reset_quiet: assert property (
        @(posedge sysclk)
        reset |=> (!req_read_bus && !req_write_bus && !reg_op_done &&
                   state == emio_bus_pkg::ST_IDLE)
    ) else $error("bridge not quiet after reset");

endmodule

// ==== verification/emio_tb.sv ====
// directed testbench for the emio subsystem
// emulates the processor side of the emio protocol and checks read data
`timescale 1ns/1ps
`include "emio_bus_macros.svh"

module emio_tb;

    localparam int CYCLE_LIMIT = 20000;    // all six tests incl. heartbeat waits
    localparam int POLL_LIMIT  = 500;

    logic        sysclk;
    logic        reset;
    logic [63:0] emio_ps_out;
    logic [63:0] emio_ps_tri;
    logic [63:0] emio_ps_in;

    int          cycle_cnt;
    int          checks;
    int          value_errors;
    int          poll_errors;
    logic [31:0] lcg_state;
    logic [31:0] main_model [16];    // expected main register contents
    logic [63:0] last_word;          // last word driven by the processor
    logic        last_write;

    tb_clock_gen #(.RESET_CYCLES(4)) clk_gen (.sysclk(sysclk), .reset(reset));

    emio_subsystem_top UUT (
        .sysclk(sysclk), .reset(reset),
        .emio_ps_out(emio_ps_out), .emio_ps_tri(emio_ps_tri), .emio_ps_in(emio_ps_in)
    );

    bind emio_bridge emio_bridge_chk bridge_chk (
        .sysclk(sysclk), .reset(reset), .state(state), .reg_wen(reg_wen),
        .grant_write_bus(grant_write_bus), .req_read_bus(req_read_bus),
        .req_write_bus(req_write_bus), .reg_op_done(reg_op_done)
    );

    always @(posedge sysclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            $display("FAILED %s: actual 0x%08h expected 0x%08h", name, actual, expected);
            value_errors++;
        end
    endtask

    // one processor word per rising edge
    task automatic drive_emio(input logic req, input logic wr, input logic blk_start,
                              input logic blk_end, input logic [15:0] addr,
                              input logic [31:0] data);
        logic [63:0] word;
        word = '0;
        word[`EMIO_REQ_BIT]       = req;
        word[`EMIO_WEN_BIT]       = wr;
        word[`EMIO_WRITE_BIT]     = wr;
        word[`EMIO_BLK_START_BIT] = blk_start;
        word[`EMIO_BLK_END_BIT]   = blk_end;
        word[`EMIO_ADDR_MSB:`EMIO_ADDR_LSB] = addr;
        word[`EMIO_DATA_MSB:`EMIO_DATA_LSB] = data;
        @(posedge sysclk);
        emio_ps_out <= word;
        emio_ps_tri <= {32'hFFC2_0000, wr ? 32'h0000_0000 : 32'hFFFF_FFFF};
        last_word  = word;
        last_write = wr;
    endtask

    // outputs are sampled on the falling edge, away from the drive edge
    task automatic wait_op_done(input logic level, input string what);
        int  n;
        logic seen;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < POLL_LIMIT) begin
            @(negedge sysclk);
            seen = (emio_ps_in[`EMIO_OP_DONE_BIT] == level);
            n++;
        end
        if (!seen) begin
            $display("op_done never went to %0b during %s", level, what);
            poll_errors++;
        end
    endtask

    // status word echoes the processor fields around a set op_done
    task automatic compare_status_echo();
        check_value("status echo", 32'(emio_ps_in[`EMIO_WRITE_BIT:`EMIO_ADDR_LSB]),
                    32'({last_write, last_word[`EMIO_BLK_END_BIT:`EMIO_WEN_BIT], 1'b1,
                         last_word[`EMIO_REQ_BIT:`EMIO_ADDR_LSB]}));
    endtask

    task automatic release_req(input string what);
        logic [63:0] word;
        word = last_word;
        word[`EMIO_REQ_BIT] = 1'b0;
        @(posedge sysclk);
        emio_ps_out <= word;
        wait_op_done(1'b0, what);
        repeat (3) @(posedge sysclk);    // bridge back in idle
    endtask

    task automatic quad_write(input logic [15:0] addr, input logic [31:0] data);
        drive_emio(1'b0, 1'b1, 1'b0, 1'b0, addr, data);
        drive_emio(1'b1, 1'b1, 1'b0, 1'b0, addr, data);
        wait_op_done(1'b1, "quadlet write");
        compare_status_echo();
        release_req("quadlet write");
        if (addr[15:4] == 12'h000)
            main_model[addr[3:0]] = data;
    endtask

    task automatic quad_read(input logic [15:0] addr, output logic [31:0] data);
        drive_emio(1'b0, 1'b0, 1'b0, 1'b0, addr, 32'h0);
        drive_emio(1'b1, 1'b0, 1'b0, 1'b0, addr, 32'h0);
        wait_op_done(1'b1, "quadlet read");
        data = emio_ps_in[`EMIO_DATA_MSB:`EMIO_DATA_LSB];
        check_value("version", 32'(emio_ps_in[`EMIO_VERSION_MSB:`EMIO_VERSION_LSB]), 32'd1);
        compare_status_echo();
        release_req("quadlet read");
    endtask

    // test 2, four quadlets from base, address changes per quadlet
    task automatic block_write(input logic [15:0] base);
        logic [31:0] d;
        d = next_rand();
        drive_emio(1'b0, 1'b1, 1'b1, 1'b0, base, d);
        drive_emio(1'b1, 1'b1, 1'b1, 1'b0, base, d);
        main_model[base[3:0]] = d;
        wait_op_done(1'b1, "block write quadlet 0");
        for (int i = 1; i < 4; i++) begin
            d = next_rand();
            drive_emio(1'b1, 1'b1, 1'b1, (i == 3), base + 16'(i), d);
            main_model[base[3:0] + 4'(i)] = d;
            wait_op_done(1'b1, "block write");
        end
        release_req("block write");
    endtask

    task automatic block_read_check(input logic [15:0] base);
        drive_emio(1'b0, 1'b0, 1'b1, 1'b0, base, 32'h0);
        drive_emio(1'b1, 1'b0, 1'b1, 1'b0, base, 32'h0);
        wait_op_done(1'b1, "block read quadlet 0");
        check_value("block rdata", emio_ps_in[31:0], main_model[base[3:0]]);
        for (int i = 1; i < 4; i++) begin
            drive_emio(1'b1, 1'b0, (i != 3), (i == 3), base + 16'(i), 32'h0);
            wait_op_done(1'b1, "block read");
            check_value("block rdata", emio_ps_in[31:0], main_model[base[3:0] + 4'(i)]);
        end
        release_req("block read");
    endtask

    // single-quadlet real-time read of main 0, start_cycle is the req edge
    task automatic rt_read(output logic [31:0] data, output int start_cycle);
        drive_emio(1'b0, 1'b0, 1'b1, 1'b1, 16'h0000, 32'h0);
        drive_emio(1'b1, 1'b0, 1'b1, 1'b1, 16'h0000, 32'h0);
        start_cycle = cycle_cnt;
        wait_op_done(1'b1, "real-time read");
        data = emio_ps_in[31:0];
        release_req("real-time read");
    endtask

    task automatic test_quadlets();
        logic [31:0] d;
        for (int i = 0; i < 4; i++) begin
            quad_write(16'(i), next_rand());
            quad_read(16'(i), d);
            check_value("quad rdata", d, main_model[i]);
        end
    endtask

    task automatic test_unmapped();
        logic [31:0] d;
        quad_read(16'h2010, d);
        check_value("unmapped rdata", d, 32'hDEADBEEF);
    endtask

    task automatic test_rt_delta();
        logic [31:0] d1;
        logic [31:0] d2;
        int          c1;
        int          c2;
        int          expected;
        rt_read(d1, c1);
        repeat (137) @(posedge sysclk);
        rt_read(d2, c2);
        expected = (c2 - c1) - 1;    // difference of the two starts, minus one
        checks++;
        if ($signed(d2) < expected - 2 || $signed(d2) > expected + 2) begin
            $display("FAILED rt_delta: actual 0x%08h expected 0x%08h +/- 2", d2, expected);
            value_errors++;
        end
    endtask

    // an open block write holds the write bus across a heartbeat tick
    task automatic test_heartbeat();
        logic [31:0] prev;
        logic [31:0] hb;
        logic [31:0] d;
        quad_read(`HUB_HEARTBEAT_ADDR, prev);
        for (int i = 0; i < 4; i++) begin
            d = next_rand();
            drive_emio(1'b0, 1'b1, 1'b1, 1'b0, 16'(8 + i), d);
            drive_emio(1'b1, 1'b1, 1'b1, 1'b0, 16'(8 + i), d);
            wait_op_done(1'b1, "held block write");
            main_model[8 + i] = d;
            repeat (230) @(posedge sysclk);    // heartbeat requests and has to wait
            release_req("held block write");
            quad_read(`HUB_HEARTBEAT_ADDR, hb);
            checks++;
            if (hb <= prev) begin
                $display("FAILED heartbeat: actual 0x%08h not above 0x%08h", hb, prev);
                value_errors++;
            end
            prev = hb;
            quad_read(16'(8 + i), d);
            check_value("contended rdata", d, main_model[8 + i]);
        end
    endtask

    task automatic test_abort();
        logic [31:0] d;
        drive_emio(1'b0, 1'b1, 1'b0, 1'b0, 16'h0002, 32'hA5A5_0002);
        drive_emio(1'b1, 1'b1, 1'b0, 1'b0, 16'h0002, 32'hA5A5_0002);
        drive_emio(1'b0, 1'b1, 1'b0, 1'b0, 16'h0002, 32'hA5A5_0002);    // req gone early
        repeat (8) @(posedge sysclk);
        @(negedge sysclk);
        check_value("bridge state", 32'(UUT.bridge.state), 32'(emio_bus_pkg::ST_IDLE));
        quad_read(16'h0002, d);
        check_value("aborted reg", d, main_model[2]);
        quad_write(16'h0003, next_rand());
        quad_read(16'h0003, d);
        check_value("post-abort rdata", d, main_model[3]);
    endtask

    initial begin
        emio_ps_out  = '0;
        emio_ps_tri  = '1;
        cycle_cnt    = 0;
        checks       = 0;
        value_errors = 0;
        poll_errors  = 0;
        lcg_state    = 32'h6104;
        last_word    = '0;
        last_write   = 1'b0;
        for (int i = 0; i < 16; i++)
            main_model[i] = 32'h0;
        wait (reset === 1'b0);
        repeat (2) @(posedge sysclk);

        test_quadlets();
        block_write(16'h0004);
        block_read_check(16'h0004);
        test_unmapped();
        test_rt_delta();
        test_heartbeat();
        test_abort();

        repeat (4) @(posedge sysclk);
        $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors,
                 poll_errors);
        if (value_errors == 0 && poll_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clock_gen.sv ====
// testbench clock and reset source
// 20 ns sysclk, reset held high for the first cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int RESET_CYCLES = 4
) (
    output logic sysclk,
    output logic reset
);

    initial begin
        sysclk = 1'b0;
        forever #10 sysclk = ~sysclk;    // 50 MHz
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge sysclk);
        reset <= 1'b0;
    end

endmodule
